/* compile.f */
hw/disk_io_pkg.sv
hw/ctl_strobe_sync.sv
hw/sector_buffer.sv
hw/block_request.sv
hw/mount_tracker.sv
hw/ctl_word_mux.sv
hw/disk_io_bridge.sv
testbench/disk_io_bridge_props.sv
testbench/tb_disk_io_bridge.sv

/* hw/block_request.sv */
// Per-drive block read/write requests towards the host sector service.
// Any ack bit clears every pending request; ack always wins over a new one.
// Done is set on the falling edge of the OR of all ack bits.

`timescale 1ns/10ps

module block_request (
	input  logic                   clk_sys,
	input  logic                   areset,
	input  disk_io_pkg::req_kind_e req_ev_i,
	input  disk_io_pkg::drive_t    drive_i,
	input  disk_io_pkg::slot_mask_t host_ack_i,
	output disk_io_pkg::slot_mask_t host_rd_o,
	output disk_io_pkg::slot_mask_t host_wr_o,
	output logic                   io_done_o
);

	logic any_ack;
	logic old_ack;

	assign any_ack = |host_ack_i;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			host_rd_o <= '0;
			host_wr_o <= '0;
			io_done_o <= 1'b0;
			old_ack   <= 1'b0;
		end else begin
			old_ack <= any_ack;

			// New request marks the drive and starts a fresh transfer
			case (req_ev_i)
				disk_io_pkg::REQ_READ: begin
					host_rd_o[drive_i] <= 1'b1;
					io_done_o          <= 1'b0;
				end
				disk_io_pkg::REQ_WRITE: begin
					host_wr_o[drive_i] <= 1'b1;
					io_done_o          <= 1'b0;
				end
				default: begin
				end
			endcase

			// Host has taken the request
			if (any_ack) begin
				host_rd_o <= '0;
				host_wr_o <= '0;
			end

			// Transfer finished
			if (old_ack && !any_ack)
				io_done_o <= 1'b1;
		end
	end

endmodule

/* hw/ctl_strobe_sync.sv */
// Turns controller strobe levels into one-cycle events.
// Levels must be held for several cycles; short glitches are not filtered.
// Block read wins over block write when both rise together.

`timescale 1ns/10ps

module ctl_strobe_sync (
	input  logic                   clk_sys,
	input  logic                   areset,
	input  logic                   ctl_data_wr_i,
	input  logic                   ctl_data_rd_i,
	input  logic                   ctl_block_rd_i,
	input  logic                   ctl_block_wr_i,
	input  logic                   ctl_io_wr_i,
	input  disk_io_pkg::slot_mask_t img_mounted_i,
	output logic                   data_wr_ev_o,
	output logic                   data_rd_ev_o,
	output disk_io_pkg::req_kind_e req_ev_o,
	output logic                   ptr_clr_o,
	output logic                   mount_ev_o
);

	// Previous samples of the controller levels
	logic old_wr;
	logic old_wr2;
	logic old_rd;
	logic old_blrd;
	logic old_blwr;
	logic old_mounted;

	logic any_mounted;

	assign any_mounted = |img_mounted_i;

	// io_wr is already a pulse on the controller side
	assign ptr_clr_o = ctl_io_wr_i;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			old_wr       <= 1'b0;
			old_wr2      <= 1'b0;
			old_rd       <= 1'b0;
			old_blrd     <= 1'b0;
			old_blwr     <= 1'b0;
			old_mounted  <= 1'b0;
			data_wr_ev_o <= 1'b0;
			data_rd_ev_o <= 1'b0;
			req_ev_o     <= disk_io_pkg::REQ_NONE;
			mount_ev_o   <= 1'b0;
		end else begin
			old_wr      <= ctl_data_wr_i;
			old_wr2     <= old_wr;
			old_rd      <= ctl_data_rd_i;
			old_blrd    <= ctl_block_rd_i;
			old_blwr    <= ctl_block_wr_i;
			old_mounted <= any_mounted;

			// Write data settles one extra stage before it is taken
			data_wr_ev_o <= old_wr & ~old_wr2;
			// Pointer advances once the controller has finished reading
			data_rd_ev_o <= old_rd & ~ctl_data_rd_i;
			mount_ev_o   <= ~old_mounted & any_mounted;

			if (~old_blrd & ctl_block_rd_i)
				req_ev_o <= disk_io_pkg::REQ_READ;
			else if (~old_blwr & ctl_block_wr_i)
				req_ev_o <= disk_io_pkg::REQ_WRITE;
			else
				req_ev_o <= disk_io_pkg::REQ_NONE;
		end
	end

endmodule

/* hw/ctl_word_mux.sv */
// Controller-side read data and status byte, purely combinational.
// With lba_sel high the data word carries the mounted image size.

`timescale 1ns/10ps

module ctl_word_mux (
	input  logic                   lba_sel_i,
	input  disk_io_pkg::byte_t      ctl_byte_i,
	input  disk_io_pkg::lba_t       size_i,
	input  logic                   io_done_i,
	input  logic                   mount_toggle_i,
	input  disk_io_pkg::drive_t     slot_i,
	input  disk_io_pkg::file_type_t type_i,
	input  logic                   read_only_i,
	output disk_io_pkg::word_t      ctl_data_o,
	output disk_io_pkg::byte_t      ctl_status_o
);

	// Status byte fields
	assign ctl_status_o[disk_io_pkg::STAT_DONE_BIT]  = io_done_i;
	assign ctl_status_o[disk_io_pkg::STAT_MOUNT_BIT] = mount_toggle_i;
	assign ctl_status_o[disk_io_pkg::STAT_SLOT_LSB +: 3] = slot_i;
	assign ctl_status_o[disk_io_pkg::STAT_TYPE_LSB +: 2] = type_i;
	assign ctl_status_o[disk_io_pkg::STAT_RO_BIT]    = read_only_i;

	// Size word or buffer byte, zero-extended
	always_comb begin
		if (lba_sel_i)
			ctl_data_o = size_i;
		else
			ctl_data_o = disk_io_pkg::word_t'(ctl_byte_i);
	end

endmodule

/* hw/disk_io_bridge.sv */
// Disk block bridge between the emulated I/O controller and the host
// SD sector service. Controller strobes are levels and must be held for
// at least 4 cycles. One sector buffer is shared by all drives.

`timescale 1ns/10ps

module disk_io_bridge (
	input  logic                    clk_sys,
	input  logic                    areset,

	// Controller side
	input  logic                    ctl_lba_sel_i,
	input  logic                    ctl_block_rd_i,
	input  logic                    ctl_block_wr_i,
	input  disk_io_pkg::drive_t      ctl_drive_i,
	input  logic                    ctl_io_wr_i,
	input  logic                    ctl_data_wr_i,
	input  logic                    ctl_data_rd_i,
	input  disk_io_pkg::word_t       ctl_wdata_i,
	output disk_io_pkg::word_t       ctl_data_o,
	output disk_io_pkg::byte_t       ctl_status_o,

	// Host sector service
	output disk_io_pkg::lba_t        host_lba_o,
	output disk_io_pkg::slot_mask_t  host_rd_o,
	output disk_io_pkg::slot_mask_t  host_wr_o,
	input  disk_io_pkg::slot_mask_t  host_ack_i,
	input  disk_io_pkg::buf_addr_t   host_buf_addr_i,
	input  disk_io_pkg::byte_t       host_buf_wdata_i,
	input  logic                    host_buf_we_i,
	output disk_io_pkg::byte_t       host_buf_rdata_o,

	// Image mount notices
	input  disk_io_pkg::slot_mask_t  img_mounted_i,
	input  logic                    img_readonly_i,
	input  disk_io_pkg::lba_t        img_size_i,
	input  disk_io_pkg::file_type_t  img_type_i
);

	logic                    data_wr_ev;
	logic                    data_rd_ev;
	disk_io_pkg::req_kind_e  req_ev;
	logic                    ptr_clr;
	logic                    mount_ev;
	disk_io_pkg::byte_t      ctl_byte;
	logic                    io_done;
	disk_io_pkg::drive_t     mnt_slot;
	disk_io_pkg::file_type_t mnt_type;
	logic                    mnt_read_only;
	disk_io_pkg::lba_t       mnt_size;
	logic                    mount_toggle;

	// ========================================================================
	// Input side
	// ========================================================================
	ctl_strobe_sync u_ctl_strobe_sync (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.ctl_data_wr_i  (ctl_data_wr_i),
		.ctl_data_rd_i  (ctl_data_rd_i),
		.ctl_block_rd_i (ctl_block_rd_i),
		.ctl_block_wr_i (ctl_block_wr_i),
		.ctl_io_wr_i    (ctl_io_wr_i),
		.img_mounted_i  (img_mounted_i),
		.data_wr_ev_o   (data_wr_ev),
		.data_rd_ev_o   (data_rd_ev),
		.req_ev_o       (req_ev),
		.ptr_clr_o      (ptr_clr),
		.mount_ev_o     (mount_ev)
	);

	// ========================================================================
	// Buffer and requests
	// ========================================================================
	sector_buffer u_sector_buffer (
		.clk_sys          (clk_sys),
		.areset           (areset),
		.data_wr_ev_i     (data_wr_ev),
		.data_rd_ev_i     (data_rd_ev),
		.ptr_clr_i        (ptr_clr),
		.lba_sel_i        (ctl_lba_sel_i),
		.wdata_i          (ctl_wdata_i),
		.host_buf_addr_i  (host_buf_addr_i),
		.host_buf_wdata_i (host_buf_wdata_i),
		.host_buf_we_i    (host_buf_we_i),
		.host_buf_rdata_o (host_buf_rdata_o),
		.ctl_byte_o       (ctl_byte),
		.host_lba_o       (host_lba_o)
	);

	block_request u_block_request (
		.clk_sys    (clk_sys),
		.areset     (areset),
		.req_ev_i   (req_ev),
		.drive_i    (ctl_drive_i),
		.host_ack_i (host_ack_i),
		.host_rd_o  (host_rd_o),
		.host_wr_o  (host_wr_o),
		.io_done_o  (io_done)
	);

	// ========================================================================
	// Output side
	// ========================================================================
	mount_tracker u_mount_tracker (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.mount_ev_i     (mount_ev),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_size_i     (img_size_i),
		.img_type_i     (img_type_i),
		.slot_o         (mnt_slot),
		.type_o         (mnt_type),
		.read_only_o    (mnt_read_only),
		.size_o         (mnt_size),
		.mount_toggle_o (mount_toggle)
	);

	ctl_word_mux u_ctl_word_mux (
		.lba_sel_i      (ctl_lba_sel_i),
		.ctl_byte_i     (ctl_byte),
		.size_i         (mnt_size),
		.io_done_i      (io_done),
		.mount_toggle_i (mount_toggle),
		.slot_i         (mnt_slot),
		.type_i         (mnt_type),
		.read_only_i    (mnt_read_only),
		.ctl_data_o     (ctl_data_o),
		.ctl_status_o   (ctl_status_o)
	);

endmodule

/* hw/disk_io_pkg.sv */
// Shared widths, types and status layout for the disk block bridge.
// One 512-byte sector buffer is shared by all eight drive slots.
// Status byte layout is fixed and is read by the controller firmware.

package disk_io_pkg;

	// ========================================================================
	// Sizes
	// ========================================================================
	localparam int SECTOR_BYTES = 512;
	localparam int BUF_ADDR_W   = 9;
	localparam int DRIVE_CNT    = 8;

	// ========================================================================
	// Data types
	// ========================================================================
	typedef logic [BUF_ADDR_W-1:0] buf_addr_t;
	typedef logic [7:0]            byte_t;
	typedef logic [31:0]           word_t;
	typedef logic [31:0]           lba_t;
	typedef logic [2:0]            drive_t;

	// One bit per slot for requests, acks and mount notices
	typedef logic [DRIVE_CNT-1:0]  slot_mask_t;

	// Image file type tag, as given by the host loader index
	typedef logic [1:0]            file_type_t;

	// ========================================================================
	// Status byte bit positions
	// ========================================================================
	localparam int STAT_DONE_BIT  = 0;
	localparam int STAT_MOUNT_BIT = 1;
	localparam int STAT_SLOT_LSB  = 2;
	localparam int STAT_TYPE_LSB  = 5;
	localparam int STAT_RO_BIT    = 7;

	// Loader image slots, never writable
	localparam int RO_SLOT_A = 4;
	localparam int RO_SLOT_B = 5;

	// Block request opcode from strobe unit to request unit
	typedef enum logic [1:0] {
		REQ_NONE  = 2'd0,
		REQ_READ  = 2'd1,
		REQ_WRITE = 2'd2
	} req_kind_e;

endpackage

/* hw/mount_tracker.sv */
// Records the last image mount notice from the host.
// Mount bits must still be held when the delayed mount event arrives.
// Slot 7 is reported only when it is the sole bit set.

`timescale 1ns/10ps

module mount_tracker (
	input  logic                    clk_sys,
	input  logic                    areset,
	input  logic                    mount_ev_i,
	input  disk_io_pkg::slot_mask_t  img_mounted_i,
	input  logic                    img_readonly_i,
	input  disk_io_pkg::lba_t        img_size_i,
	input  disk_io_pkg::file_type_t  img_type_i,
	output disk_io_pkg::drive_t      slot_o,
	output disk_io_pkg::file_type_t  type_o,
	output logic                    read_only_o,
	output disk_io_pkg::lba_t        size_o,
	output logic                    mount_toggle_o
);

	disk_io_pkg::drive_t slot_next;

	// Highest mounted slot among 0..6, previous slot if none
	always_comb begin
		slot_next = slot_o;
		for (int i = 0; i < disk_io_pkg::DRIVE_CNT - 1; i++) begin
			if (img_mounted_i[i])
				slot_next = disk_io_pkg::drive_t'(i);
		end
		if (img_mounted_i == 8'h80)
			slot_next = 3'd7;
	end

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			slot_o         <= '0;
			type_o         <= '0;
			read_only_o    <= 1'b0;
			mount_toggle_o <= 1'b0;
		end else if (mount_ev_i) begin
			slot_o         <= slot_next;
			type_o         <= img_type_i;
			// Loader slots are never written back
			read_only_o    <= img_readonly_i | img_mounted_i[disk_io_pkg::RO_SLOT_A]
			                  | img_mounted_i[disk_io_pkg::RO_SLOT_B];
			mount_toggle_o <= ~mount_toggle_o;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (mount_ev_i)
			size_o <= img_size_i;
	end

endmodule

/* hw/sector_buffer.sv */
// Shared 512-byte sector buffer with a controller-side byte pointer.
// The host port has its own address; no arbitration between the ports,
// a host write to the same byte in the same cycle wins.
// Read data on both ports is registered, one cycle behind the address.

`timescale 1ns/10ps

module sector_buffer (
	input  logic                  clk_sys,
	input  logic                  areset,
	input  logic                  data_wr_ev_i,
	input  logic                  data_rd_ev_i,
	input  logic                  ptr_clr_i,
	input  logic                  lba_sel_i,
	input  disk_io_pkg::word_t     wdata_i,
	input  disk_io_pkg::buf_addr_t host_buf_addr_i,
	input  disk_io_pkg::byte_t     host_buf_wdata_i,
	input  logic                  host_buf_we_i,
	output disk_io_pkg::byte_t     host_buf_rdata_o,
	output disk_io_pkg::byte_t     ctl_byte_o,
	output disk_io_pkg::lba_t      host_lba_o
);

	disk_io_pkg::byte_t mem [disk_io_pkg::SECTOR_BYTES];

	disk_io_pkg::buf_addr_t ptr;
	logic                   byte_wr_q;
	logic                   ctl_byte_we;

	assign ctl_byte_we = data_wr_ev_i & ~lba_sel_i;

	// ========================================================================
	// Buffer array, both ports
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (ctl_byte_we)
			mem[ptr] <= wdata_i[7:0];
		if (host_buf_we_i)
			mem[host_buf_addr_i] <= host_buf_wdata_i;

		ctl_byte_o       <= mem[ptr];
		host_buf_rdata_o <= mem[host_buf_addr_i];
	end

	// ========================================================================
	// Controller pointer
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			ptr       <= '0;
			byte_wr_q <= 1'b0;
		end else begin
			byte_wr_q <= ctl_byte_we;
			// Clear has priority over any advance
			if (ptr_clr_i)
				ptr <= '0;
			else if (byte_wr_q || data_rd_ev_i)
				ptr <= ptr + 1'b1;
		end
	end

	// Block address for the host, loaded by a write with lba_sel high
	always_ff @(posedge clk_sys) begin
		if (data_wr_ev_i && lba_sel_i)
			host_lba_o <= wdata_i;
	end

endmodule

/* testbench/disk_io_bridge_props.sv */
// Bound checks on the host request masks and the I/O done flag.
// fail_cnt counts failed assertions so the testbench can end the run.

`timescale 1ns/10ps

module disk_io_bridge_props (
	input  logic                    clk_sys,
	input  logic                    areset,
	input  disk_io_pkg::slot_mask_t host_rd_i,
	input  disk_io_pkg::slot_mask_t host_wr_i,
	input  disk_io_pkg::slot_mask_t host_ack_i,
	input  logic                    io_done_i
);

	int fail_cnt = 0;

	// Read wins when both strobes rise, so the masks never overlap in time
	a_rd_wr_exclusive: assert property (
		@(posedge clk_sys) disable iff (areset)
		!((|host_rd_i) && (|host_wr_i))
	) else begin
		fail_cnt++;
		$error("host_rd_o and host_wr_o are both non-zero");
	end

	a_done_low_on_req: assert property (
		@(posedge clk_sys) disable iff (areset)
		((|host_rd_i) || (|host_wr_i)) |-> !io_done_i
	) else begin
		fail_cnt++;
		$error("I/O done is set while a request bit is pending");
	end

	// Any ack bit clears every pending request on the next clock
	a_ack_clears_req: assert property (
		@(posedge clk_sys) disable iff (areset)
		(|host_ack_i) |=> ((host_rd_i == '0) && (host_wr_i == '0))
	) else begin
		fail_cnt++;
		$error("Request bits still set one cycle after ack");
	end

endmodule

bind disk_io_bridge disk_io_bridge_props u_disk_io_bridge_props (
	.clk_sys    (clk_sys),
	.areset     (areset),
	.host_rd_i  (host_rd_o),
	.host_wr_i  (host_wr_o),
	.host_ack_i (host_ack_i),
	.io_done_i  (io_done)
);

/* testbench/disk_io_testdata.txt */
# op a b c d e (hex): LBA word exp | WBYTE data | HOSTW addr data | HOSTR addr exp | RBYTE exp | CLR
# REQ drive kind(1 rd, 2 wr, 3 both) exp_rd exp_wr | MOUNT mask ro type size exp_status
LBA   12345678 12345678 0 0 0
LBA   0000a5c3 0000a5c3 0 0 0
CLR   0 0 0 0 0
WBYTE 11 0 0 0 0
LBA   00000055 00000055 0 0 0
WBYTE 22 0 0 0 0
WBYTE ffffff44 0 0 0 0
WBYTE 80 0 0 0 0
HOSTR 0 11 0 0 0
HOSTR 1 22 0 0 0
HOSTR 2 44 0 0 0
HOSTR 3 80 0 0 0
HOSTW 0 a0 0 0 0
HOSTW 1 b1 0 0 0
HOSTW 2 c2 0 0 0
HOSTW 3 d3 0 0 0
HOSTW 1ff 5e 0 0 0
HOSTR 1ff 5e 0 0 0
CLR   0 0 0 0 0
RBYTE 000000a0 0 0 0 0
RBYTE 000000b1 0 0 0 0
RBYTE 000000c2 0 0 0 0
RBYTE 000000d3 0 0 0 0
REQ   3 1 08 00 0
REQ   6 2 00 40 0
REQ   0 3 01 00 0
REQ   7 1 80 00 0
REQ   2 2 00 04 0
MOUNT 02 0 1 00001000 26
MOUNT 10 0 2 00000800 d0
MOUNT 20 0 3 00001234 f6
MOUNT 80 0 0 00020000 1c
MOUNT 84 1 1 00000040 aa
MOUNT 03 0 2 00000100 44
MOUNT 30 0 0 0000ffff 96
MOUNT 41 1 3 00000000 f8
LBA   cafe0001 cafe0001 0 0 0

/* testbench/tb_disk_io_bridge.sv */
// Testbench for the disk block bridge, driven from a test data file.
// Run from the project root so the data file path resolves.
// Inputs change 5 ns after the rising edge, outputs are sampled at the falling edge.

`timescale 1ns/10ps

module tb_disk_io_bridge;

	logic                    clk_sys;
	logic                    areset;
	logic                    ctl_lba_sel;
	logic                    ctl_block_rd;
	logic                    ctl_block_wr;
	disk_io_pkg::drive_t     ctl_drive;
	logic                    ctl_io_wr;
	logic                    ctl_data_wr;
	logic                    ctl_data_rd;
	disk_io_pkg::word_t      ctl_wdata;
	disk_io_pkg::word_t      ctl_data;
	disk_io_pkg::byte_t      ctl_status;
	disk_io_pkg::lba_t       host_lba;
	disk_io_pkg::slot_mask_t host_rd;
	disk_io_pkg::slot_mask_t host_wr;
	disk_io_pkg::slot_mask_t host_ack;
	disk_io_pkg::buf_addr_t  host_buf_addr;
	disk_io_pkg::byte_t      host_buf_wdata;
	logic                    host_buf_we;
	disk_io_pkg::byte_t      host_buf_rdata;
	disk_io_pkg::slot_mask_t img_mounted;
	logic                    img_readonly;
	disk_io_pkg::lba_t       img_size;
	disk_io_pkg::file_type_t img_type;
	disk_io_pkg::byte_t      done_mask;

	// Operations loaded from the data file
	string              op_name [128];
	disk_io_pkg::word_t op_arg  [128][5];
	int                 op_cnt = 0;
	logic               ops_loaded = 1'b0;
	integer             seed;

	assign done_mask = disk_io_pkg::byte_t'(1) << disk_io_pkg::STAT_DONE_BIT;

	disk_io_bridge u_disk_io_bridge (
		.clk_sys (clk_sys), .areset (areset),
		.ctl_lba_sel_i (ctl_lba_sel), .ctl_block_rd_i (ctl_block_rd),
		.ctl_block_wr_i (ctl_block_wr), .ctl_drive_i (ctl_drive),
		.ctl_io_wr_i (ctl_io_wr), .ctl_data_wr_i (ctl_data_wr),
		.ctl_data_rd_i (ctl_data_rd), .ctl_wdata_i (ctl_wdata),
		.ctl_data_o (ctl_data), .ctl_status_o (ctl_status),
		.host_lba_o (host_lba), .host_rd_o (host_rd), .host_wr_o (host_wr),
		.host_ack_i (host_ack), .host_buf_addr_i (host_buf_addr),
		.host_buf_wdata_i (host_buf_wdata), .host_buf_we_i (host_buf_we),
		.host_buf_rdata_o (host_buf_rdata), .img_mounted_i (img_mounted),
		.img_readonly_i (img_readonly), .img_size_i (img_size),
		.img_type_i (img_type)
	);

	// ========================================================================
	// Helpers
	// ========================================================================
	task fail_run();
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic step_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#5;
	endtask

	task automatic sample_point();
		@(negedge clk_sys);
	endtask

	task automatic check_word(input string name, input disk_io_pkg::word_t exp,
	                          input disk_io_pkg::word_t act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_byte(input string name, input disk_io_pkg::byte_t exp,
	                          input disk_io_pkg::byte_t act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_mask(input string name, input disk_io_pkg::slot_mask_t exp,
	                          input disk_io_pkg::slot_mask_t act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %b, actual %b", name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_status(input string name, input disk_io_pkg::byte_t exp,
	                            input disk_io_pkg::byte_t act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %b, actual %b", name, exp, act);
			fail_run();
		end
	endtask

	task automatic load_ops();
		int                 fd;
		int                 n;
		string              op;
		disk_io_pkg::word_t a [5];
		logic [8*160-1:0]   line;
		fd = $fopen("testbench/disk_io_testdata.txt", "r");
		if (fd == 0) begin
			$display("Cannot open test data file testbench/disk_io_testdata.txt");
			fail_run();
		end
		while (!$feof(fd)) begin
			line = '0;
			n = $fgets(line, fd);
			if (n > 0)
				n = $sscanf(line, "%s %h %h %h %h %h", op, a[0], a[1], a[2], a[3], a[4]);
			// Comment and blank lines are skipped
			if (n > 0 && op[0] != "#") begin
				if (n != 6 || op_cnt >= $size(op_name)) begin
					$display("Bad or excess line %0d in test data", op_cnt + 1);
					fail_run();
				end
				op_name[op_cnt] = op;
				for (int k = 0; k < 5; k++)
					op_arg[op_cnt][k] = a[k];
				op_cnt++;
			end
		end
		$fclose(fd);
	endtask

	// Host side of a block transfer: ack after a short gap, hold it, release
	task automatic serve_request(input disk_io_pkg::slot_mask_t req);
		int gap;
		int len;
		gap = 1 + ({$random(seed)} % 4);
		len = 1 + ({$random(seed)} % 8);
		step_cycles(gap);
		host_ack = req;
		step_cycles(len);
		host_ack = '0;
	endtask

	task automatic wait_done(input string name);
		int n;
		n = 0;
		sample_point();
		while (ctl_status[disk_io_pkg::STAT_DONE_BIT] !== 1'b1 && n < 16) begin
			sample_point();
			n++;
		end
		if (ctl_status[disk_io_pkg::STAT_DONE_BIT] !== 1'b1) begin
			$display("I/O done flag not set within 16 cycles after ack in %s", name);
			fail_run();
		end
	endtask

	// ========================================================================
	// Operations
	// ========================================================================
	task automatic do_lba(input string name, input disk_io_pkg::word_t word,
	                      input disk_io_pkg::lba_t exp);
		ctl_lba_sel = 1'b1;
		ctl_wdata   = word;
		ctl_data_wr = 1'b1;
		step_cycles(4);
		ctl_data_wr = 1'b0;
		step_cycles(4);
		sample_point();
		check_word(name, exp, host_lba);
		step_cycles(1);
		ctl_lba_sel = 1'b0;
	endtask

	task automatic do_wbyte(input disk_io_pkg::word_t word);
		ctl_lba_sel = 1'b0;
		ctl_wdata   = word;
		ctl_data_wr = 1'b1;
		step_cycles(4);
		ctl_data_wr = 1'b0;
		step_cycles(4);
	endtask

	task automatic do_rbyte(input string name, input disk_io_pkg::word_t exp);
		ctl_lba_sel = 1'b0;
		sample_point();
		check_word(name, exp, ctl_data);
		step_cycles(1);
		// Falling edge of the read level moves to the next byte
		ctl_data_rd = 1'b1;
		step_cycles(4);
		ctl_data_rd = 1'b0;
		step_cycles(4);
	endtask

	task automatic do_req(input string name, input disk_io_pkg::drive_t drive,
	                      input logic [1:0] kind, input disk_io_pkg::slot_mask_t exp_rd,
	                      input disk_io_pkg::slot_mask_t exp_wr);
		ctl_drive    = drive;
		ctl_block_rd = kind[0];
		ctl_block_wr = kind[1];
		step_cycles(4);
		sample_point();
		check_mask({name, " rd"}, exp_rd, host_rd);
		check_mask({name, " wr"}, exp_wr, host_wr);
		check_status({name, " done low"}, 8'h00, ctl_status & done_mask);
		step_cycles(1);
		ctl_block_rd = 1'b0;
		ctl_block_wr = 1'b0;
		serve_request(host_rd | host_wr);
		wait_done(name);
		check_mask({name, " rd clear"}, '0, host_rd);
		check_mask({name, " wr clear"}, '0, host_wr);
		check_status({name, " done high"}, done_mask, ctl_status & done_mask);
		step_cycles(1);
	endtask

	task automatic do_mount(input string name, input disk_io_pkg::slot_mask_t mask,
	                        input logic ro, input disk_io_pkg::file_type_t ftype,
	                        input disk_io_pkg::lba_t size, input disk_io_pkg::byte_t exp);
		img_mounted  = mask;
		img_readonly = ro;
		img_type     = ftype;
		img_size     = size;
		step_cycles(4);
		img_mounted = '0;
		step_cycles(4);
		sample_point();
		// Done bit belongs to the request path
		check_status(name, exp & ~done_mask, ctl_status & ~done_mask);
		step_cycles(1);
		ctl_lba_sel = 1'b1;
		sample_point();
		check_word({name, " size"}, size, ctl_data);
		step_cycles(1);
		ctl_lba_sel = 1'b0;
	endtask

	task automatic run_op(input int i);
		string name;
		name = $sformatf("%s #%0d", op_name[i], i + 1);
		if (op_name[i] == "LBA")
			do_lba(name, op_arg[i][0], op_arg[i][1]);
		else if (op_name[i] == "WBYTE")
			do_wbyte(op_arg[i][0]);
		else if (op_name[i] == "RBYTE")
			do_rbyte(name, op_arg[i][0]);
		else if (op_name[i] == "CLR") begin
			ctl_io_wr = 1'b1;
			step_cycles(1);
			ctl_io_wr = 1'b0;
			step_cycles(3);
		end else if (op_name[i] == "HOSTW") begin
			host_buf_addr  = disk_io_pkg::buf_addr_t'(op_arg[i][0]);
			host_buf_wdata = disk_io_pkg::byte_t'(op_arg[i][1]);
			host_buf_we    = 1'b1;
			step_cycles(1);
			host_buf_we = 1'b0;
			step_cycles(1);
		end else if (op_name[i] == "HOSTR") begin
			host_buf_addr = disk_io_pkg::buf_addr_t'(op_arg[i][0]);
			step_cycles(2);
			sample_point();
			check_byte(name, disk_io_pkg::byte_t'(op_arg[i][1]), host_buf_rdata);
			step_cycles(1);
		end else if (op_name[i] == "REQ")
			do_req(name, disk_io_pkg::drive_t'(op_arg[i][0]), op_arg[i][1][1:0],
			       disk_io_pkg::slot_mask_t'(op_arg[i][2]),
			       disk_io_pkg::slot_mask_t'(op_arg[i][3]));
		else if (op_name[i] == "MOUNT")
			do_mount(name, disk_io_pkg::slot_mask_t'(op_arg[i][0]), op_arg[i][1][0],
			         disk_io_pkg::file_type_t'(op_arg[i][2]), op_arg[i][3],
			         disk_io_pkg::byte_t'(op_arg[i][4]));
		else begin
			$display("Unknown operation %s in test data", op_name[i]);
			fail_run();
		end
	endtask

	// ========================================================================
	// Clock, watchdog, assertion monitor and main sequence
	// ========================================================================
	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	initial begin
		wait (ops_loaded);
		repeat (op_cnt * 60 + 100) @(posedge clk_sys);
		$display("Timeout: test sequence did not finish in %0d cycles", op_cnt * 60 + 100);
		fail_run();
	end

	always @(negedge clk_sys) begin
		if (u_disk_io_bridge.u_disk_io_bridge_props.fail_cnt != 0) begin
			$display("A bound assertion on request or done behaviour failed");
			fail_run();
		end
	end

	initial begin
		seed           = 32'h7bd8;
		areset         = 1'b1;
		ctl_lba_sel    = 1'b0;
		ctl_block_rd   = 1'b0;
		ctl_block_wr   = 1'b0;
		ctl_drive      = '0;
		ctl_io_wr      = 1'b0;
		ctl_data_wr    = 1'b0;
		ctl_data_rd    = 1'b0;
		ctl_wdata      = '0;
		host_ack       = '0;
		host_buf_addr  = '0;
		host_buf_wdata = '0;
		host_buf_we    = 1'b0;
		img_mounted    = '0;
		img_readonly   = 1'b0;
		img_size       = '0;
		img_type       = '0;

		load_ops();
		ops_loaded = 1'b1;

		step_cycles(16);
		areset = 1'b0;
		sample_point();
		check_mask("reset rd", '0, host_rd);
		check_mask("reset wr", '0, host_wr);
		check_status("reset status", 8'h00, ctl_status);
		step_cycles(1);

		for (int i = 0; i < op_cnt; i++)
			run_op(i);

		if (u_disk_io_bridge.u_disk_io_bridge_props.fail_cnt == 0) begin
			$display("No errors");
			$finish;
		end else begin
			fail_run();
		end
	end

endmodule
